/* rtl/nkmm_macros.svh */
`ifndef NKMM_MACROS_SVH
`define NKMM_MACROS_SVH

// instruction word
`define NKMM_INSN_WIDTH 32

// registers and data bus
`define NKMM_DATA_WIDTH 32

// program and data address
`define NKMM_ADDR_WIDTH 16

// immediate field, zero-extended to the data width
`define NKMM_IMM_WIDTH 16

// register selector fields d, a and b
`define NKMM_REGSEL_WIDTH 3

// alu operation field
`define NKMM_OPSEL_WIDTH 3

`endif

/* rtl/nkmm_pkg.sv */
`include "nkmm_macros.svh"

package nkmm_pkg;

    // alu operations
    typedef enum logic [`NKMM_OPSEL_WIDTH-1:0] {
        ADD   = 3'd0,
        SUB   = 3'd1,
        OR    = 3'd2,
        AND   = 3'd3,
        XOR   = 3'd4,
        NOT   = 3'd5,  // inverts b
        SHI   = 3'd6,  // shifts a
        PASSB = 3'd7   // result is b
    } op_e;

    // register selects
    typedef enum logic [`NKMM_REGSEL_WIDTH-1:0] {
        R0 = 3'd0,  // reads zero, writes ignored
        RA = 3'd1,
        RB = 3'd2,
        RC = 3'd3,
        RD = 3'd4,
        RE = 3'd5,
        SP = 3'd6,
        PC = 3'd7   // reads own address, write jumps
    } reg_sel_e;

    // shift amount in b[1:0], b[2] set for left
    typedef enum logic [1:0] {
        S1 = 2'd0,
        S2 = 2'd1,
        S4 = 2'd2,
        S8 = 2'd3
    } shi_e;

endpackage

/* rtl/nkmm_fetch.sv */
`timescale 1ns/1ps
`include "nkmm_macros.svh"

module nkmm_fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall_i,
    input  logic                        redirect_i,
    input  logic [`NKMM_ADDR_WIDTH-1:0] redirect_pc_i,
    input  logic [`NKMM_INSN_WIDTH-1:0] prog_data_i,
    output logic [`NKMM_ADDR_WIDTH-1:0] prog_addr_o,
    output logic [`NKMM_INSN_WIDTH-1:0] if_insn_o,
    output logic [`NKMM_ADDR_WIDTH-1:0] if_pc_o,
    output logic                        if_valid_o
);
    logic [`NKMM_ADDR_WIDTH-1:0] pc;
    // word requested last cycle, arriving on prog_data_i now
    logic [`NKMM_ADDR_WIDTH-1:0] fl_pc;
    logic                        fl_valid;

    // while stalled, request the in-flight word again so it arrives once more
    assign prog_addr_o = stall_i ? fl_pc : pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            fl_valid   <= 1'b0;
            if_valid_o <= 1'b0;
        end else if (redirect_i) begin
            // drop the held word and the one still in flight
            pc         <= redirect_pc_i;
            fl_valid   <= 1'b0;
            if_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc         <= pc + 1'b1;
            fl_valid   <= 1'b1;
            if_valid_o <= fl_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            fl_pc     <= pc;
            if_insn_o <= prog_data_i;
            if_pc_o   <= fl_pc;
        end
    end

endmodule

/* rtl/nkmm_decode.sv */
`timescale 1ns/1ps
`include "nkmm_macros.svh"

module nkmm_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  logic [`NKMM_INSN_WIDTH-1:0] if_insn_i,
    input  logic [`NKMM_ADDR_WIDTH-1:0] if_pc_i,
    input  logic                        if_valid_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] rf_a_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] rf_b_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] rf_d_i,
    input  nkmm_pkg::reg_sel_e          ex_d_sel_i,
    input  logic                        ex_valid_i,
    input  nkmm_pkg::reg_sel_e          mio_d_sel_i,
    input  logic                        mio_valid_i,
    output nkmm_pkg::reg_sel_e          rf_a_sel_o,
    output nkmm_pkg::reg_sel_e          rf_b_sel_o,
    output nkmm_pkg::reg_sel_e          rf_d_sel_o,
    output logic                        stall_o,
    output nkmm_pkg::op_e               dcd_op_o,
    output logic [`NKMM_DATA_WIDTH-1:0] dcd_alu_a_o,
    output logic [`NKMM_DATA_WIDTH-1:0] dcd_alu_b_o,
    output logic [`NKMM_DATA_WIDTH-1:0] dcd_reg_d_o,
    output nkmm_pkg::reg_sel_e          dcd_d_sel_o,
    output logic                        dcd_mem_read_o,
    output logic                        dcd_mem_write_o,
    output logic                        dcd_valid_o
);
    import nkmm_pkg::*;

    logic                        mem_write;
    logic                        mem_read;
    logic                        imm_en;
    op_e                         op;
    logic [`NKMM_IMM_WIDTH-1:0]  imm;
    logic [`NKMM_DATA_WIDTH-1:0] pc_value;
    logic [`NKMM_DATA_WIDTH-1:0] alu_a;
    logic [`NKMM_DATA_WIDTH-1:0] alu_b;
    logic [`NKMM_DATA_WIDTH-1:0] reg_d;
    logic                        hz_dcd;
    logic                        hz_ex;
    logic                        hz_mio;

    // older instruction with destination dst blocks the one in decode
    function automatic logic hazard(input reg_sel_e dst, input logic dst_valid);
        logic reads;
        reads = (dst == rf_a_sel_o) || (!imm_en && dst == rf_b_sel_o) ||
                (mem_write && dst == rf_d_sel_o);
        // a pending jump also holds decode, so nothing younger slips past it
        return dst_valid && dst != R0 && (reads || dst == PC);
    endfunction

    // fixed fields
    assign mem_write  = if_insn_i[30];
    assign mem_read   = if_insn_i[29];
    assign rf_d_sel_o = reg_sel_e'(if_insn_i[28:26]);
    assign op         = op_e'(if_insn_i[25:23]);
    assign rf_a_sel_o = reg_sel_e'(if_insn_i[22:20]);
    assign rf_b_sel_o = reg_sel_e'(if_insn_i[19:17]);
    assign imm_en     = if_insn_i[16];
    assign imm        = if_insn_i[15:0];

    assign pc_value = {{(`NKMM_DATA_WIDTH-`NKMM_ADDR_WIDTH){1'b0}}, if_pc_i};

    always_comb begin
        hz_dcd  = hazard(dcd_d_sel_o, dcd_valid_o);
        hz_ex   = hazard(ex_d_sel_i, ex_valid_i);
        hz_mio  = hazard(mio_d_sel_i, mio_valid_i);
        stall_o = if_valid_i && (hz_dcd || hz_ex || hz_mio);
    end

    // regfile returns zero for R0 and PC, PC value comes from here
    always_comb begin
        alu_a = (rf_a_sel_o == PC) ? pc_value : rf_a_i;
        if (imm_en) begin
            alu_b = {{(`NKMM_DATA_WIDTH-`NKMM_IMM_WIDTH){1'b0}}, imm};
        end else begin
            alu_b = (rf_b_sel_o == PC) ? pc_value : rf_b_i;
        end
        reg_d = (rf_d_sel_o == PC) ? pc_value : rf_d_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dcd_valid_o     <= 1'b0;
            dcd_mem_read_o  <= 1'b0;
            dcd_mem_write_o <= 1'b0;
        end else begin
            // bubble on stall or flush
            dcd_valid_o     <= if_valid_i && !stall_o && !flush_i;
            dcd_mem_read_o  <= mem_read;
            dcd_mem_write_o <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        dcd_op_o    <= op;
        dcd_alu_a_o <= alu_a;
        dcd_alu_b_o <= alu_b;
        dcd_reg_d_o <= reg_d;
        dcd_d_sel_o <= rf_d_sel_o;
    end

endmodule

/* rtl/nkmm_regfile.sv */
`timescale 1ns/1ps
`include "nkmm_macros.svh"

module nkmm_regfile (
    input  logic                        clk,
    input  logic                        rst,
    input  nkmm_pkg::reg_sel_e          a_sel_i,
    input  nkmm_pkg::reg_sel_e          b_sel_i,
    input  nkmm_pkg::reg_sel_e          d_sel_i,
    input  logic                        wb_valid_i,
    input  nkmm_pkg::reg_sel_e          wb_sel_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] wb_data_i,
    output logic [`NKMM_DATA_WIDTH-1:0] a_o,
    output logic [`NKMM_DATA_WIDTH-1:0] b_o,
    output logic [`NKMM_DATA_WIDTH-1:0] d_o
);
    import nkmm_pkg::*;

    // RA through SP
    logic [`NKMM_DATA_WIDTH-1:0] regs [RA:SP];

    function automatic logic [`NKMM_DATA_WIDTH-1:0] read_port(input reg_sel_e sel);
        logic [`NKMM_DATA_WIDTH-1:0] value;
        value = '0;
        if (sel inside {[RA:SP]}) begin
            // write-through, so the value retiring this cycle is seen by decode
            if (wb_valid_i && wb_sel_i == sel) begin
                value = wb_data_i;
            end else begin
                value = regs[sel];
            end
        end
        return value;
    endfunction

    always_comb begin
        a_o = read_port(a_sel_i);
        b_o = read_port(b_sel_i);
        d_o = read_port(d_sel_i);
    end

    // PC writes are taken by fetch, R0 writes are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wb_valid_i && wb_sel_i inside {[RA:SP]}) begin
            regs[wb_sel_i] <= wb_data_i;
        end
    end

endmodule

/* rtl/nkmm_execute.sv */
`timescale 1ns/1ps
`include "nkmm_macros.svh"

module nkmm_execute (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  nkmm_pkg::op_e               dcd_op_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] dcd_alu_a_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] dcd_alu_b_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] dcd_reg_d_i,
    input  nkmm_pkg::reg_sel_e          dcd_d_sel_i,
    input  logic                        dcd_mem_read_i,
    input  logic                        dcd_mem_write_i,
    input  logic                        dcd_valid_i,
    output logic [`NKMM_DATA_WIDTH-1:0] ex_alu_r_o,
    output logic [`NKMM_DATA_WIDTH-1:0] ex_reg_d_o,
    output nkmm_pkg::reg_sel_e          ex_d_sel_o,
    output logic                        ex_mem_read_o,
    output logic                        ex_mem_write_o,
    output logic                        ex_valid_o
);
    import nkmm_pkg::*;

    logic                        shl;
    shi_e                        amount;
    logic [3:0]                  shamt;
    logic [`NKMM_DATA_WIDTH-1:0] shifted;
    logic [`NKMM_DATA_WIDTH-1:0] alu_r;

    // shift control in the low bits of b
    assign shl    = dcd_alu_b_i[2];
    assign amount = shi_e'(dcd_alu_b_i[1:0]);

    always_comb begin
        case (amount)
            S1:      shamt = 4'd1;
            S2:      shamt = 4'd2;
            S4:      shamt = 4'd4;
            default: shamt = 4'd8;
        endcase
        shifted = shl ? (dcd_alu_a_i << shamt) : (dcd_alu_a_i >> shamt);
        case (dcd_op_i)
            ADD:     alu_r = dcd_alu_a_i + dcd_alu_b_i;
            SUB:     alu_r = dcd_alu_a_i - dcd_alu_b_i;
            OR:      alu_r = dcd_alu_a_i | dcd_alu_b_i;
            AND:     alu_r = dcd_alu_a_i & dcd_alu_b_i;
            XOR:     alu_r = dcd_alu_a_i ^ dcd_alu_b_i;
            NOT:     alu_r = ~dcd_alu_b_i;
            SHI:     alu_r = shifted;
            default: alu_r = dcd_alu_b_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_o     <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
        end else begin
            ex_valid_o     <= dcd_valid_i && !flush_i;
            ex_mem_read_o  <= dcd_mem_read_i;
            ex_mem_write_o <= dcd_mem_write_i;
        end
    end

    // result doubles as the data address, reg_d is the store data
    always_ff @(posedge clk) begin
        ex_alu_r_o <= alu_r;
        ex_reg_d_o <= dcd_reg_d_i;
        ex_d_sel_o <= dcd_d_sel_i;
    end

endmodule

/* rtl/nkmm_memio.sv */
`timescale 1ns/1ps
`include "nkmm_macros.svh"

module nkmm_memio (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`NKMM_DATA_WIDTH-1:0] data_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] ex_alu_r_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] ex_reg_d_i,
    input  nkmm_pkg::reg_sel_e          ex_d_sel_i,
    input  logic                        ex_mem_read_i,
    input  logic                        ex_mem_write_i,
    input  logic                        ex_valid_i,
    output logic [`NKMM_ADDR_WIDTH-1:0] addr_o,
    output logic [`NKMM_DATA_WIDTH-1:0] data_o,
    output logic                        we_o,
    output nkmm_pkg::reg_sel_e          mio_d_sel_o,
    output logic                        mio_valid_o,
    output logic                        wb_valid_o,
    output nkmm_pkg::reg_sel_e          wb_sel_o,
    output logic [`NKMM_DATA_WIDTH-1:0] wb_data_o
);
    import nkmm_pkg::*;

    logic [`NKMM_DATA_WIDTH-1:0] mio_alu_r;
    logic                        mio_mem_read;
    logic                        mio_mem_write;

    // data bus straight from the execute register
    assign addr_o = ex_alu_r_i[`NKMM_ADDR_WIDTH-1:0];
    assign data_o = ex_reg_d_i;
    assign we_o   = ex_mem_write_i && ex_valid_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            mio_valid_o   <= 1'b0;
            mio_mem_read  <= 1'b0;
            mio_mem_write <= 1'b0;
            wb_valid_o    <= 1'b0;
        end else begin
            mio_valid_o   <= ex_valid_i;
            mio_mem_read  <= ex_mem_read_i;
            mio_mem_write <= ex_mem_write_i;
            // stores and R0 targets retire without a write
            wb_valid_o    <= mio_valid_o && !mio_mem_write && mio_d_sel_o != R0;
        end
    end

    always_ff @(posedge clk) begin
        mio_alu_r   <= ex_alu_r_i;
        mio_d_sel_o <= ex_d_sel_i;
        wb_sel_o    <= mio_d_sel_o;
        // load word arrives one cycle after the address
        wb_data_o   <= mio_mem_read ? data_i : mio_alu_r;
    end

endmodule

/* rtl/nkmm_cpu.sv */
`timescale 1ns/1ps
`include "nkmm_macros.svh"

module nkmm_cpu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`NKMM_INSN_WIDTH-1:0] prog_data_i,
    input  logic [`NKMM_DATA_WIDTH-1:0] data_i,
    output logic [`NKMM_ADDR_WIDTH-1:0] prog_addr_o,
    output logic [`NKMM_ADDR_WIDTH-1:0] addr_o,
    output logic [`NKMM_DATA_WIDTH-1:0] data_o,
    output logic                        we_o
);
    import nkmm_pkg::*;

    // fetch to decode
    logic [`NKMM_INSN_WIDTH-1:0] if_insn;
    logic [`NKMM_ADDR_WIDTH-1:0] if_pc;
    logic                        if_valid;
    logic                        stall;

    // decode and register file
    reg_sel_e                    rf_a_sel;
    reg_sel_e                    rf_b_sel;
    reg_sel_e                    rf_d_sel;
    logic [`NKMM_DATA_WIDTH-1:0] rf_a;
    logic [`NKMM_DATA_WIDTH-1:0] rf_b;
    logic [`NKMM_DATA_WIDTH-1:0] rf_d;

    // decode to execute
    op_e                         dcd_op;
    logic [`NKMM_DATA_WIDTH-1:0] dcd_alu_a;
    logic [`NKMM_DATA_WIDTH-1:0] dcd_alu_b;
    logic [`NKMM_DATA_WIDTH-1:0] dcd_reg_d;
    reg_sel_e                    dcd_d_sel;
    logic                        dcd_mem_read;
    logic                        dcd_mem_write;
    logic                        dcd_valid;

    // execute to memio
    logic [`NKMM_DATA_WIDTH-1:0] ex_alu_r;
    logic [`NKMM_DATA_WIDTH-1:0] ex_reg_d;
    reg_sel_e                    ex_d_sel;
    logic                        ex_mem_read;
    logic                        ex_mem_write;
    logic                        ex_valid;

    // memio and writeback
    reg_sel_e                    mio_d_sel;
    logic                        mio_valid;
    logic                        wb_valid;
    reg_sel_e                    wb_sel;
    logic [`NKMM_DATA_WIDTH-1:0] wb_data;
    logic                        redirect;

    // a retiring PC write is the jump
    assign redirect = wb_valid && wb_sel == PC;

    nkmm_fetch u_fetch (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (wb_data[`NKMM_ADDR_WIDTH-1:0]),
        .prog_data_i   (prog_data_i),
        .prog_addr_o   (prog_addr_o),
        .if_insn_o     (if_insn),
        .if_pc_o       (if_pc),
        .if_valid_o    (if_valid)
    );

    nkmm_decode u_decode (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (redirect),
        .if_insn_i       (if_insn),
        .if_pc_i         (if_pc),
        .if_valid_i      (if_valid),
        .rf_a_i          (rf_a),
        .rf_b_i          (rf_b),
        .rf_d_i          (rf_d),
        .ex_d_sel_i      (ex_d_sel),
        .ex_valid_i      (ex_valid),
        .mio_d_sel_i     (mio_d_sel),
        .mio_valid_i     (mio_valid),
        .rf_a_sel_o      (rf_a_sel),
        .rf_b_sel_o      (rf_b_sel),
        .rf_d_sel_o      (rf_d_sel),
        .stall_o         (stall),
        .dcd_op_o        (dcd_op),
        .dcd_alu_a_o     (dcd_alu_a),
        .dcd_alu_b_o     (dcd_alu_b),
        .dcd_reg_d_o     (dcd_reg_d),
        .dcd_d_sel_o     (dcd_d_sel),
        .dcd_mem_read_o  (dcd_mem_read),
        .dcd_mem_write_o (dcd_mem_write),
        .dcd_valid_o     (dcd_valid)
    );

    nkmm_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .a_sel_i    (rf_a_sel),
        .b_sel_i    (rf_b_sel),
        .d_sel_i    (rf_d_sel),
        .wb_valid_i (wb_valid),
        .wb_sel_i   (wb_sel),
        .wb_data_i  (wb_data),
        .a_o        (rf_a),
        .b_o        (rf_b),
        .d_o        (rf_d)
    );

    nkmm_execute u_execute (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (redirect),
        .dcd_op_i        (dcd_op),
        .dcd_alu_a_i     (dcd_alu_a),
        .dcd_alu_b_i     (dcd_alu_b),
        .dcd_reg_d_i     (dcd_reg_d),
        .dcd_d_sel_i     (dcd_d_sel),
        .dcd_mem_read_i  (dcd_mem_read),
        .dcd_mem_write_i (dcd_mem_write),
        .dcd_valid_i     (dcd_valid),
        .ex_alu_r_o      (ex_alu_r),
        .ex_reg_d_o      (ex_reg_d),
        .ex_d_sel_o      (ex_d_sel),
        .ex_mem_read_o   (ex_mem_read),
        .ex_mem_write_o  (ex_mem_write),
        .ex_valid_o      (ex_valid)
    );

    nkmm_memio u_memio (
        .clk            (clk),
        .rst            (rst),
        .data_i         (data_i),
        .ex_alu_r_i     (ex_alu_r),
        .ex_reg_d_i     (ex_reg_d),
        .ex_d_sel_i     (ex_d_sel),
        .ex_mem_read_i  (ex_mem_read),
        .ex_mem_write_i (ex_mem_write),
        .ex_valid_i     (ex_valid),
        .addr_o         (addr_o),
        .data_o         (data_o),
        .we_o           (we_o),
        .mio_d_sel_o    (mio_d_sel),
        .mio_valid_o    (mio_valid),
        .wb_valid_o     (wb_valid),
        .wb_sel_o       (wb_sel),
        .wb_data_o      (wb_data)
    );

endmodule

/* verification/nkmm_ref_model.svh */
`ifndef NKMM_REF_MODEL_SVH
`define NKMM_REF_MODEL_SVH

// instruction word from its fields
function automatic logic [31:0] encode(input logic wr, input logic rd, input logic [2:0] d,
                                       input logic [2:0] op, input logic [2:0] a,
                                       input logic [2:0] b, input logic ie,
                                       input logic [15:0] imm);
    return {1'b0, wr, rd, d, op, a, b, ie, imm};
endfunction

function automatic logic [31:0] alu_r(input logic [2:0] op, input logic [2:0] d,
                                      input logic [2:0] a, input logic [2:0] b);
    return encode(1'b0, 1'b0, d, op, a, b, 1'b0, 16'h0);
endfunction

function automatic logic [31:0] alu_i(input logic [2:0] op, input logic [2:0] d,
                                      input logic [2:0] a, input logic [15:0] imm);
    return encode(1'b0, 1'b0, d, op, a, 3'd0, 1'b1, imm);
endfunction

// store d to a + imm
function automatic logic [31:0] st(input logic [2:0] d, input logic [2:0] a,
                                   input logic [15:0] imm);
    return encode(1'b1, 1'b0, d, 3'd0, a, 3'd0, 1'b1, imm);
endfunction

// load d from a + imm
function automatic logic [31:0] ld(input logic [2:0] d, input logic [2:0] a,
                                   input logic [15:0] imm);
    return encode(1'b0, 1'b1, d, 3'd0, a, 3'd0, 1'b1, imm);
endfunction

function automatic logic [31:0] jmp(input logic [15:0] target);
    return encode(1'b0, 1'b0, 3'd7, 3'd7, 3'd0, 3'd0, 1'b1, target);
endfunction

// R0 is zero, PC is the reading instruction's address
function automatic logic [31:0] arch_read(input logic [31:0] regs [8], input logic [2:0] sel,
                                          input logic [15:0] pc);
    if (sel == 3'd0) begin
        return 32'h0;
    end
    if (sel == 3'd7) begin
        return {16'h0, pc};
    end
    return regs[sel];
endfunction

function automatic logic [31:0] ref_alu(input logic [2:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
    int amt;
    amt = 1 << b[1:0];
    case (op)
        3'd0:    return a + b;
        3'd1:    return a - b;
        3'd2:    return a | b;
        3'd3:    return a & b;
        3'd4:    return a ^ b;
        3'd5:    return ~b;
        3'd6:    return b[2] ? (a << amt) : (a >> amt);
        default: return b;
    endcase
endfunction

// runs prog architecturally until the self-jump, fills the expected store queues
function automatic int ref_run();
    logic [31:0] regs [8];
    logic [31:0] mem [256];
    logic [15:0] pc;
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] dv;
    logic [2:0]  dsel;
    int          steps;
    logic        done;
    regs = '{default: 32'h0};
    mem = ram_init;
    pc = 16'h0;
    steps = 0;
    done = 1'b0;
    exp_addr.delete();
    exp_data.delete();
    while (!done && steps < 4000) begin
        insn = prog[pc[7:0]];
        steps++;
        dsel = insn[28:26];
        a = arch_read(regs, insn[22:20], pc);
        b = insn[16] ? {16'h0, insn[15:0]} : arch_read(regs, insn[19:17], pc);
        r = ref_alu(insn[25:23], a, b);
        if (insn[30]) begin
            dv = arch_read(regs, dsel, pc);
            exp_addr.push_back(r[15:0]);
            exp_data.push_back(dv);
            mem[r[7:0]] = dv;
            pc = pc + 16'd1;
        end else begin
            if (insn[29]) begin
                r = mem[r[7:0]];
            end
            if (dsel == 3'd7) begin
                done = (r[15:0] == pc);
                pc = r[15:0];
            end else begin
                if (dsel != 3'd0) begin
                    regs[dsel] = r;
                end
                pc = pc + 16'd1;
            end
        end
    end
    return steps;
endfunction

`endif

/* verification/nkmm_tb.sv */
`timescale 1ns/1ps
`include "nkmm_macros.svh"

module nkmm_tb;
    import nkmm_pkg::*;

    logic        clk;
    logic        rst;
    logic [31:0] prog_data_i;
    logic [31:0] data_i;
    logic [15:0] prog_addr_o;
    logic [15:0] addr_o;
    logic [31:0] data_o;
    logic        we_o;

    logic [31:0] prog [256];
    logic [31:0] ram_init [256];
    logic [31:0] ram [256];
    logic [15:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          plen;
    int          obs_count;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          budget;
    int          wd_cycles;
    logic [15:0] pa;
    logic [15:0] da;
    logic [31:0] dd;
    logic        dw;

    `include "nkmm_ref_model.svh"

    nkmm_cpu uut (
        .clk         (clk),
        .rst         (rst),
        .prog_data_i (prog_data_i),
        .data_i      (data_i),
        .prog_addr_o (prog_addr_o),
        .addr_o      (addr_o),
        .data_o      (data_o),
        .we_o        (we_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // program rom and data ram with one cycle of read latency
    always @(posedge clk) begin
        pa = prog_addr_o;
        da = addr_o;
        dd = data_o;
        dw = we_o;
        #1;
        if (dw) begin
            ram[da[7:0]] = dd;
        end
        prog_data_i = prog[pa[7:0]];
        data_i = ram[da[7:0]];
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // compares each store as it happens
    always @(posedge clk) begin
        if (!rst && we_o) begin
            if (obs_count < exp_addr.size()) begin
                check_value("addr_o", {16'h0, addr_o}, {16'h0, exp_addr[obs_count]});
                check_value("data_o", data_o, exp_data[obs_count]);
            end else begin
                $display("unexpected extra store of 0x%08h to 0x%04h", data_o, addr_o);
                errors++;
            end
            obs_count++;
        end
    end

    initial begin
        wd_cycles = 0;
        while (wd_cycles <= budget) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("timeout: the run took longer than its cycle budget");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic clear_prog();
        for (int i = 0; i < 256; i++) begin
            prog[i] = 32'h0;
            ram_init[i] = 32'h3c000000 ^ (i * 32'h00010203);
        end
        plen = 0;
    endtask

    task automatic emit(input logic [31:0] insn);
        prog[plen] = insn;
        plen++;
    endtask

    // self-jump ends every program
    task automatic emit_halt();
        emit(jmp(plen[15:0]));
    endtask

    task automatic run_test(input int num, input string name);
        int steps;
        int err0;
        int n;
        steps = ref_run();
        budget += (steps + 10) * 8;
        err0 = errors;
        @(posedge clk);
        #1;
        rst = 1'b1;
        ram = ram_init;
        obs_count = 0;
        repeat (5) @(posedge clk);
        #1;
        check_value("prog_addr_o", {16'h0, prog_addr_o}, 32'h0);
        check_value("we_o", {31'h0, we_o}, 32'h0);
        rst = 1'b0;
        n = 0;
        while (obs_count < exp_addr.size() && n < steps * 6 + 20) begin
            @(posedge clk);
            n++;
        end
        // room for stores that should not happen
        repeat (16) @(posedge clk);
        if (obs_count != exp_addr.size()) begin
            $display("test %0d saw %0d stores but expected %0d", num, obs_count,
                     exp_addr.size());
            errors++;
        end
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d stores, %s", num, name, exp_addr.size(),
                 (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        op_e ops [8];
        rst = 1'b1;
        prog_data_i = 32'h0;
        data_i = 32'h0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        obs_count = 0;
        budget = 40;
        ops = '{ADD, SUB, OR, AND, XOR, NOT, SHI, PASSB};
        void'($urandom(91468));

        clear_prog();
        emit(alu_i(PASSB, RA, R0, 16'h1234));
        emit(alu_i(PASSB, RB, R0, 16'h00f6));
        for (int k = 0; k < 8; k++) begin
            emit(alu_i(ops[k], RC, RA, 16'h0ff5));
            emit(st(RC, R0, 16'h10 + 16'(k)));
            emit(alu_r(ops[k], RD, RA, RB));
            emit(st(RD, R0, 16'h18 + 16'(k)));
        end
        emit_halt();
        run_test(1, "alu ops");

        clear_prog();
        emit(alu_i(PASSB, RA, R0, 16'd5));
        emit(alu_i(ADD, RB, RA, 16'd3));
        emit(alu_r(XOR, RC, RB, RA));
        emit(alu_r(SUB, RD, RC, RB));
        emit(st(RD, RD, 16'h20));
        emit(alu_r(ADD, RE, RD, RD));
        emit(st(RE, R0, 16'h21));
        emit(alu_r(OR, SP, RE, RA));
        emit(st(SP, SP, 16'h0));
        emit_halt();
        run_test(2, "dependent chains");

        clear_prog();
        ram_init[8'h30] = 32'hcafe0001;
        ram_init[8'h31] = 32'h12345678;
        emit(alu_i(PASSB, RA, R0, 16'h30));
        emit(ld(RB, RA, 16'd0));
        emit(ld(RC, RA, 16'd1));
        emit(alu_r(ADD, RD, RB, RC));
        emit(st(RD, R0, 16'h40));
        emit(st(RB, RA, 16'h20));
        emit(ld(RE, R0, 16'h40));
        emit(alu_r(XOR, RE, RE, RB));
        emit(st(RE, R0, 16'h41));
        emit_halt();
        run_test(3, "loads");

        clear_prog();
        emit(alu_i(PASSB, RA, R0, 16'h8421));
        for (int k = 0; k < 4; k++) begin
            emit(alu_i(SHI, RC, RA, 16'h4 | 16'(k)));
            emit(st(RC, R0, 16'h50 + 16'(k)));
            emit(alu_i(SHI, RC, RA, 16'(k)));
            emit(st(RC, R0, 16'h58 + 16'(k)));
        end
        emit(st(PC, R0, 16'h60));
        emit(alu_r(ADD, RB, PC, R0));
        emit(st(RB, R0, 16'h61));
        emit(alu_i(PASSB, R0, R0, 16'h77));
        emit(st(R0, R0, 16'h62));
        emit_halt();
        run_test(4, "shifts, PC and R0");

        // jump table at 9 picks the loop exit when RB reaches zero
        clear_prog();
        emit(alu_i(PASSB, RA, R0, 16'd1));
        emit(jmp(16'd4));
        emit(st(RA, R0, 16'h7e));
        emit(st(RA, R0, 16'h7f));
        emit(alu_i(PASSB, RB, R0, 16'd3));
        emit(st(RB, RB, 16'h70));
        emit(alu_i(SUB, RB, RB, 16'd1));
        emit(alu_i(ADD, PC, RB, 16'd9));
        emit(st(RA, R0, 16'h7d));
        emit(jmp(16'd12));
        emit(jmp(16'd5));
        emit(jmp(16'd5));
        emit_halt();
        run_test(5, "jumps and loop");

        for (int t = 0; t < 4; t++) begin
            clear_prog();
            for (int r = 1; r < 7; r++) begin
                emit(alu_i(PASSB, 3'(r), R0, 16'($urandom)));
            end
            for (int i = 0; i < 24; i++) begin
                case ($urandom % 4)
                    0: emit(alu_r(3'($urandom % 8), 3'($urandom % 7), 3'($urandom % 8),
                                  3'($urandom % 8)));
                    1: emit(alu_i(3'($urandom % 8), 3'($urandom % 7), 3'($urandom % 8),
                                  16'($urandom)));
                    2: emit(ld(3'($urandom % 7), 3'($urandom % 8), 16'($urandom % 256)));
                    default: emit(st(3'($urandom % 8), 3'($urandom % 8),
                                     16'($urandom % 256)));
                endcase
            end
            emit_halt();
            run_test(6 + t, "random program");
        end

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
+incdir+verification
rtl/nkmm_pkg.sv
rtl/nkmm_fetch.sv
rtl/nkmm_decode.sv
rtl/nkmm_regfile.sv
rtl/nkmm_execute.sv
rtl/nkmm_memio.sv
rtl/nkmm_cpu.sv
verification/nkmm_tb.sv

/* Bender.yml */
package:
  name: nkmm

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/nkmm_pkg.sv
      - rtl/nkmm_fetch.sv
      - rtl/nkmm_decode.sv
      - rtl/nkmm_regfile.sv
      - rtl/nkmm_execute.sv
      - rtl/nkmm_memio.sv
      - rtl/nkmm_cpu.sv
  - target: test
    include_dirs:
      - rtl
      - verification
    files:
      - verification/nkmm_tb.sv
